// ==== decode_config.svh ====
////////////////////////////////////////
// Decode stage configuration
// Widths and feature switches
////////////////////////////////////////
`ifndef DECODE_CONFIG_SVH
`define DECODE_CONFIG_SVH

`define DEC_XLEN        32  // Data and PC width
`define DEC_NUM_WARPS   4
`define DEC_NUM_THREADS 4   // Thread mask width
`define DEC_UUID_W      8   // Trace uuid width

// Multiply/divide decode
`define DEC_EXT_M       1

`endif

// ==== rv_isa_pkg.sv ====
////////////////////////////////////////
// RISC-V encodings
// Opcodes, funct and system codes, and
// the instruction field layout
////////////////////////////////////////
package rv_isa_pkg;

    localparam logic [6:0] INST_I     = 7'b0010011;
    localparam logic [6:0] INST_R     = 7'b0110011;
    localparam logic [6:0] INST_LUI   = 7'b0110111;
    localparam logic [6:0] INST_AUIPC = 7'b0010111;
    localparam logic [6:0] INST_JAL   = 7'b1101111;
    localparam logic [6:0] INST_JALR  = 7'b1100111;
    localparam logic [6:0] INST_B     = 7'b1100011;
    localparam logic [6:0] INST_L     = 7'b0000011;
    localparam logic [6:0] INST_S     = 7'b0100011;
    localparam logic [6:0] INST_FENCE = 7'b0001111;
    localparam logic [6:0] INST_SYS   = 7'b1110011;
    localparam logic [6:0] INST_EXT1  = 7'b0001011; // custom-0, warp control

    localparam logic [6:0] INST_R_F7_MUL = 7'b0000001;

    // System immediates
    localparam logic [11:0] SYS_ECALL  = 12'h000;
    localparam logic [11:0] SYS_EBREAK = 12'h001;
    localparam logic [11:0] SYS_URET   = 12'h002;
    localparam logic [11:0] SYS_SRET   = 12'h102;
    localparam logic [11:0] SYS_MRET   = 12'h302;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
    } r_hi_t;

    // Top 12 bits seen as funct7/rs2 or as the I immediate
    typedef union packed {
        r_hi_t       r;
        logic [11:0] u_12;
    } hi_t;

    typedef struct packed {
        hi_t        hi;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } instr_fields_t;

endpackage

// ==== gpu_decode_pkg.sv ====
////////////////////////////////////////
// Decode pipeline types
// Units, operation codes, arguments and
// the records passed between stages
////////////////////////////////////////
`include "decode_config.svh"

package gpu_decode_pkg;

    localparam int WID_W = (`DEC_NUM_WARPS > 1) ? $clog2(`DEC_NUM_WARPS) : 1;

    typedef enum logic [1:0] {EX_ALU, EX_LSU, EX_SFU} ex_type_e;

    typedef enum logic [1:0] {
        ALU_TYPE_ARITH, ALU_TYPE_BRANCH, ALU_TYPE_MULDIV
    } alu_xtype_e;

    typedef logic [3:0] op_type_t; // Meaning set by ex_type

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
        ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_LUI, ALU_AUIPC
    } alu_op_e;

    typedef enum logic [3:0] {
        BR_BEQ, BR_BNE, BR_BLT, BR_BGE, BR_BLTU, BR_BGEU,
        BR_ECALL, BR_EBREAK, BR_URET, BR_SRET, BR_MRET, BR_JAL, BR_JALR
    } br_op_e;

    typedef enum logic [3:0] {
        M_MUL, M_MULH, M_MULHSU, M_MULHU, M_DIV, M_DIVU, M_REM, M_REMU
    } mul_op_e;

    typedef enum logic [3:0] {
        SFU_TMC, SFU_WSPAWN, SFU_SPLIT, SFU_JOIN,
        SFU_BARRIER, SFU_PRED, SFU_ARRIVE, SFU_WAIT,
        SFU_CSRRW = 4'd8, SFU_CSRRS, SFU_CSRRC
    } sfu_op_e;

    // Loads are {0,funct3}, stores {1,funct3}
    localparam op_type_t LSU_FENCE = 4'hf;

    typedef struct packed {
        alu_xtype_e  xtype;
        logic        use_pc;
        logic        use_imm;
        logic [19:0] imm20;
    } alu_args_t;

    typedef struct packed {
        logic [10:0] rsvd;
        logic        is_store;
        logic [11:0] offset12;
    } lsu_args_t;

    typedef struct packed {
        logic [3:0]  rsvd;
        logic        is_write; // CSR access writes
        logic        is_neg;   // Warp control polarity
        logic        use_imm;
        logic [4:0]  imm5;
        logic [11:0] addr12;
    } csr_args_t;

    typedef union packed {
        alu_args_t alu;
        lsu_args_t lsu;
        csr_args_t csr;
    } op_args_t;

    typedef logic [4:0] reg_id_t;

    typedef struct packed {
        logic [`DEC_UUID_W-1:0]      uuid;
        logic [WID_W-1:0]            wid;
        logic [`DEC_NUM_THREADS-1:0] tmask;
        logic [`DEC_XLEN-1:0]        pc;
        logic [31:0]                 instr;
    } fetch_t;

    typedef struct packed {
        logic [`DEC_UUID_W-1:0]      uuid;
        logic [WID_W-1:0]            wid;
        logic [`DEC_NUM_THREADS-1:0] tmask;
        logic [`DEC_XLEN-1:0]        pc;
        ex_type_e                    ex_type;
        op_type_t                    op_type;
        op_args_t                    op_args;
        logic                        wb;
        logic [2:0]                  used_rs; // rs3, rs2, rs1
        reg_id_t                     rd;
        reg_id_t                     rs1;
        reg_id_t                     rs2;
    } decoded_t;

    typedef struct packed {
        logic [WID_W-1:0] wid;
        logic             unlock;
    } sched_note_t;

endpackage

// ==== op_select.sv ====
`timescale 1ns/10ps
////////////////////////////////////////
// Field and operation decode
// Slices the instruction, builds the
// immediates and funct operation codes
////////////////////////////////////////
module op_select (
    input  logic [31:0]               instr,
    output rv_isa_pkg::instr_fields_t fields,
    output gpu_decode_pkg::op_type_t  alu_op,
    output gpu_decode_pkg::op_type_t  br_op,
    output gpu_decode_pkg::op_type_t  sys_op,
    output gpu_decode_pkg::op_type_t  mul_op,
    output logic [11:0]               i_imm,
    output logic [11:0]               s_imm,
    output logic [11:0]               b_imm,
    output logic [19:0]               ui_imm,
    output logic [19:0]               jal_imm,
    output logic                      csr_write
);

    logic is_itype_sh;
    logic is_sub;

    assign fields      = rv_isa_pkg::instr_fields_t'(instr);
    assign is_itype_sh = fields.funct3[0] && !fields.funct3[1]; // SLLI, SRLI, SRAI
    assign is_sub      = fields.opcode[5] && fields.hi.r.funct7[5];

    assign i_imm   = is_itype_sh ? {7'b0, fields.hi.r.rs2} : fields.hi.u_12;
    assign s_imm   = {fields.hi.r.funct7, fields.rd};
    assign b_imm   = {instr[31], instr[7], instr[30:25], instr[11:8]};
    assign ui_imm  = instr[31:12];
    assign jal_imm = {instr[31], instr[19:12], instr[20], instr[30:21]};

    always_comb begin
        case (fields.funct3)
            3'h0: alu_op = is_sub ? gpu_decode_pkg::ALU_SUB : gpu_decode_pkg::ALU_ADD;
            3'h1: alu_op = gpu_decode_pkg::ALU_SLL;
            3'h2: alu_op = gpu_decode_pkg::ALU_SLT;
            3'h3: alu_op = gpu_decode_pkg::ALU_SLTU;
            3'h4: alu_op = gpu_decode_pkg::ALU_XOR;
            3'h5: alu_op = fields.hi.r.funct7[5] ? gpu_decode_pkg::ALU_SRA
                                                 : gpu_decode_pkg::ALU_SRL;
            3'h6: alu_op = gpu_decode_pkg::ALU_OR;
            default: alu_op = gpu_decode_pkg::ALU_AND;
        endcase
    end

    always_comb begin
        case (fields.funct3)
            3'h1: br_op = gpu_decode_pkg::BR_BNE;
            3'h4: br_op = gpu_decode_pkg::BR_BLT;
            3'h5: br_op = gpu_decode_pkg::BR_BGE;
            3'h6: br_op = gpu_decode_pkg::BR_BLTU;
            3'h7: br_op = gpu_decode_pkg::BR_BGEU;
            default: br_op = gpu_decode_pkg::BR_BEQ;
        endcase
    end

    always_comb begin
        case (fields.hi.u_12)
            rv_isa_pkg::SYS_EBREAK: sys_op = gpu_decode_pkg::BR_EBREAK;
            rv_isa_pkg::SYS_URET:   sys_op = gpu_decode_pkg::BR_URET;
            rv_isa_pkg::SYS_SRET:   sys_op = gpu_decode_pkg::BR_SRET;
            rv_isa_pkg::SYS_MRET:   sys_op = gpu_decode_pkg::BR_MRET;
            default:                sys_op = gpu_decode_pkg::BR_ECALL;
        endcase
    end

    // M codes follow funct3 order
    assign mul_op = gpu_decode_pkg::op_type_t'(gpu_decode_pkg::M_MUL) + {1'b0, fields.funct3};

    always_comb begin
        case (fields.funct3)
            3'b001, 3'b101: csr_write = 1'b1;                  // CSRRW, CSRRWI
            3'b010, 3'b011,
            3'b110, 3'b111: csr_write = (fields.rs1 != 5'd0); // Set/clear, rs1 or uimm
            default:        csr_write = 1'b0;
        endcase
    end

endmodule

// ==== unit_decode.sv ====
`timescale 1ns/10ps
////////////////////////////////////////
// Execute unit routing
// Picks unit, operation and arguments,
// register usage and the warp stall
////////////////////////////////////////
`include "decode_config.svh"

module unit_decode (
    input  rv_isa_pkg::instr_fields_t fields,
    input  gpu_decode_pkg::op_type_t  alu_op,
    input  gpu_decode_pkg::op_type_t  br_op,
    input  gpu_decode_pkg::op_type_t  sys_op,
    input  gpu_decode_pkg::op_type_t  mul_op,
    input  logic [11:0]               i_imm,
    input  logic [11:0]               s_imm,
    input  logic [11:0]               b_imm,
    input  logic [19:0]               ui_imm,
    input  logic [19:0]               jal_imm,
    input  logic                      csr_write,
    output gpu_decode_pkg::ex_type_e  ex_type,
    output gpu_decode_pkg::op_type_t  op_type,
    output gpu_decode_pkg::op_args_t  op_args,
    output logic                      wb,
    output logic [2:0]                used_rs,
    output gpu_decode_pkg::reg_id_t   rd,
    output gpu_decode_pkg::reg_id_t   rs1,
    output gpu_decode_pkg::reg_id_t   rs2,
    output logic                      wstall
);

    logic        use_rd;
    logic        use_rs1;
    logic        use_rs2;
    logic        is_mul;
    logic [19:0] u12_sext;

    assign is_mul   = (`DEC_EXT_M != 0) && (fields.hi.r.funct7 == rv_isa_pkg::INST_R_F7_MUL);
    assign u12_sext = {{8{fields.hi.u_12[11]}}, fields.hi.u_12};

    always_comb begin
        ex_type = gpu_decode_pkg::EX_ALU;
        op_type = '0;
        op_args = '0; // ARITH, no PC, no imm
        wstall  = 1'b0;
        use_rd  = 1'b0;
        use_rs1 = 1'b0;
        use_rs2 = 1'b0;
        case (fields.opcode)
            rv_isa_pkg::INST_I: begin
                op_type = alu_op;
                op_args.alu.use_imm = 1'b1;
                op_args.alu.imm20 = {{8{i_imm[11]}}, i_imm};
                use_rd  = 1'b1;
                use_rs1 = 1'b1;
            end
            rv_isa_pkg::INST_R: begin
                op_type = is_mul ? mul_op : alu_op;
                if (is_mul) begin
                    op_args.alu.xtype = gpu_decode_pkg::ALU_TYPE_MULDIV;
                end
                use_rd  = 1'b1;
                use_rs1 = 1'b1;
                use_rs2 = 1'b1;
            end
            rv_isa_pkg::INST_LUI,
            rv_isa_pkg::INST_AUIPC: begin
                op_type = fields.opcode[5] ? gpu_decode_pkg::ALU_LUI : gpu_decode_pkg::ALU_AUIPC;
                op_args.alu.use_pc  = !fields.opcode[5];
                op_args.alu.use_imm = 1'b1;
                op_args.alu.imm20   = ui_imm;
                use_rd = 1'b1;
            end
            rv_isa_pkg::INST_JAL: begin
                op_type = gpu_decode_pkg::BR_JAL;
                op_args.alu.xtype   = gpu_decode_pkg::ALU_TYPE_BRANCH;
                op_args.alu.use_pc  = 1'b1;
                op_args.alu.use_imm = 1'b1;
                op_args.alu.imm20   = jal_imm;
                wstall = 1'b1;
                use_rd = 1'b1;
            end
            rv_isa_pkg::INST_JALR: begin
                op_type = gpu_decode_pkg::BR_JALR;
                op_args.alu.xtype   = gpu_decode_pkg::ALU_TYPE_BRANCH;
                op_args.alu.use_imm = 1'b1;
                op_args.alu.imm20   = u12_sext;
                wstall  = 1'b1;
                use_rd  = 1'b1;
                use_rs1 = 1'b1;
            end
            rv_isa_pkg::INST_B: begin
                op_type = br_op;
                op_args.alu.xtype   = gpu_decode_pkg::ALU_TYPE_BRANCH;
                op_args.alu.use_pc  = 1'b1;
                op_args.alu.use_imm = 1'b1;
                op_args.alu.imm20   = {{8{b_imm[11]}}, b_imm};
                wstall  = 1'b1;
                use_rs1 = 1'b1;
                use_rs2 = 1'b1;
            end
            rv_isa_pkg::INST_L,
            rv_isa_pkg::INST_S: begin
                ex_type = gpu_decode_pkg::EX_LSU;
                op_type = {fields.opcode[5], fields.funct3};
                op_args.lsu.is_store = fields.opcode[5];
                op_args.lsu.offset12 = fields.opcode[5] ? s_imm : fields.hi.u_12;
                use_rd  = !fields.opcode[5];
                use_rs1 = 1'b1;
                use_rs2 = fields.opcode[5]; // Store data
            end
            rv_isa_pkg::INST_FENCE: begin
                ex_type = gpu_decode_pkg::EX_LSU;
                op_type = gpu_decode_pkg::LSU_FENCE;
            end
            rv_isa_pkg::INST_SYS: begin
                use_rd = 1'b1;
                if (fields.funct3[1:0] != 2'b00) begin
                    ex_type = gpu_decode_pkg::EX_SFU;
                    case (fields.funct3[1:0])
                        2'b01:   op_type = gpu_decode_pkg::SFU_CSRRW;
                        2'b10:   op_type = gpu_decode_pkg::SFU_CSRRS;
                        default: op_type = gpu_decode_pkg::SFU_CSRRC;
                    endcase
                    op_args.csr.addr12   = fields.hi.u_12;
                    op_args.csr.use_imm  = fields.funct3[2];
                    op_args.csr.imm5     = fields.rs1;
                    op_args.csr.is_write = csr_write;
                    use_rs1 = !fields.funct3[2];
                end else begin
                    // Trap and return redirect with PC + 4
                    op_type = sys_op;
                    op_args.alu.xtype   = gpu_decode_pkg::ALU_TYPE_BRANCH;
                    op_args.alu.use_pc  = 1'b1;
                    op_args.alu.use_imm = 1'b1;
                    op_args.alu.imm20   = 20'd4;
                    wstall = 1'b1;
                end
            end
            rv_isa_pkg::INST_EXT1: begin
                if (fields.hi.r.funct7 == 7'h00) begin
                    ex_type = gpu_decode_pkg::EX_SFU;
                    op_type = {1'b0, fields.funct3}; // TMC..WAIT
                    wstall  = 1'b1;
                    use_rs1 = 1'b1;
                    use_rs2 = fields.funct3 inside {3'h1, 3'h4, 3'h5, 3'h6, 3'h7};
                    use_rd  = fields.funct3 inside {3'h2, 3'h6}; // SPLIT, ARRIVE
                    if (fields.funct3 == 3'h2) begin
                        op_args.csr.is_neg = fields.hi.r.rs2[0];
                    end else if (fields.funct3 == 3'h5) begin
                        op_args.csr.is_neg = fields.rd[0];
                    end
                end
            end
            default: ;
        endcase
    end

    assign rd      = use_rd ? fields.rd : '0;
    assign rs1     = use_rs1 ? fields.rs1 : '0;
    assign rs2     = use_rs2 ? fields.hi.r.rs2 : '0;
    assign used_rs = {1'b0, use_rs2, use_rs1};
    assign wb      = use_rd && (fields.rd != 5'd0); // No writes to x0

endmodule

// ==== decode_buf.sv ====
`timescale 1ns/10ps
////////////////////////////////////////
// Decode result buffer
// One-entry elastic register to issue
////////////////////////////////////////
module decode_buf (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     in_valid,
    output logic                     in_ready,
    input  gpu_decode_pkg::decoded_t in_data,
    output logic                     out_valid,
    input  logic                     out_ready,
    output gpu_decode_pkg::decoded_t out_data
);

    // Accept when empty or draining this cycle
    assign in_ready = !out_valid || out_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else if (in_ready) begin
            out_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            out_data <= in_data;
        end
    end

endmodule

// ==== decode_stage.sv ====
`timescale 1ns/10ps
////////////////////////////////////////
// SIMT instruction decode stage
// Decodes fetched words toward issue and
// notifies the warp scheduler
////////////////////////////////////////
module decode_stage (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        fetch_valid,
    output logic                        fetch_ready,
    input  gpu_decode_pkg::fetch_t      fetch_data,
    output logic                        issue_valid,
    input  logic                        issue_ready,
    output gpu_decode_pkg::decoded_t    issue_data,
    output logic                        sched_valid,
    output gpu_decode_pkg::sched_note_t sched_data
);

    rv_isa_pkg::instr_fields_t fields;
    gpu_decode_pkg::op_type_t  alu_op;
    gpu_decode_pkg::op_type_t  br_op;
    gpu_decode_pkg::op_type_t  sys_op;
    gpu_decode_pkg::op_type_t  mul_op;
    logic [11:0]               i_imm;
    logic [11:0]               s_imm;
    logic [11:0]               b_imm;
    logic [19:0]               ui_imm;
    logic [19:0]               jal_imm;
    logic                      csr_write;
    logic                      wstall;
    gpu_decode_pkg::decoded_t  dec;

    op_select op_select0 (
        .instr     (fetch_data.instr),
        .fields    (fields),
        .alu_op    (alu_op),
        .br_op     (br_op),
        .sys_op    (sys_op),
        .mul_op    (mul_op),
        .i_imm     (i_imm),
        .s_imm     (s_imm),
        .b_imm     (b_imm),
        .ui_imm    (ui_imm),
        .jal_imm   (jal_imm),
        .csr_write (csr_write)
    );

    unit_decode unit_decode0 (
        .fields    (fields),
        .alu_op    (alu_op),
        .br_op     (br_op),
        .sys_op    (sys_op),
        .mul_op    (mul_op),
        .i_imm     (i_imm),
        .s_imm     (s_imm),
        .b_imm     (b_imm),
        .ui_imm    (ui_imm),
        .jal_imm   (jal_imm),
        .csr_write (csr_write),
        .ex_type   (dec.ex_type),
        .op_type   (dec.op_type),
        .op_args   (dec.op_args),
        .wb        (dec.wb),
        .used_rs   (dec.used_rs),
        .rd        (dec.rd),
        .rs1       (dec.rs1),
        .rs2       (dec.rs2),
        .wstall    (wstall)
    );

    // Fetch-side fields ride along
    assign dec.uuid  = fetch_data.uuid;
    assign dec.wid   = fetch_data.wid;
    assign dec.tmask = fetch_data.tmask;
    assign dec.pc    = fetch_data.pc;

    decode_buf decode_buf0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (fetch_valid),
        .in_ready  (fetch_ready),
        .in_data   (dec),
        .out_valid (issue_valid),
        .out_ready (issue_ready),
        .out_data  (issue_data)
    );

    assign sched_valid       = fetch_valid && fetch_ready; // Strobe per accepted fetch
    assign sched_data.wid    = fetch_data.wid;
    assign sched_data.unlock = !wstall;

endmodule

// ==== decode_asserts.sv ====
`timescale 1ns/10ps
////////////////////////////////////////
// Decode stage assertions
// Issue hold under stall, scheduler
// strobe and quiet outputs in reset
////////////////////////////////////////
module decode_asserts (
    input logic                        clk,
    input logic                        rst_n,
    input logic                        fetch_valid,
    input logic                        fetch_ready,
    input logic                        issue_valid,
    input logic                        issue_ready,
    input gpu_decode_pkg::decoded_t    issue_data,
    input logic                        sched_valid,
    input gpu_decode_pkg::sched_note_t sched_data
);

    int fail_cnt = 0;

    // Stalled output keeps its item
    property p_issue_hold;
        @(posedge clk) disable iff (!rst_n)
            issue_valid && !issue_ready |=> issue_valid && $stable(issue_data);
    endproperty

    // Each strobe marks an item that reaches issue next cycle
    property p_sched_on_transfer;
        @(posedge clk) disable iff (!rst_n)
            sched_valid |=> issue_valid && (issue_data.wid == $past(sched_data.wid));
    endproperty

    property p_quiet_reset;
        @(posedge clk) !rst_n |-> !issue_valid && !sched_valid;
    endproperty

    a_issue_hold: assert property (p_issue_hold)
        else begin
            $error("issue_data changed while issue was stalled");
            fail_cnt++;
        end
    a_sched_on_transfer: assert property (p_sched_on_transfer)
        else begin
            $error("sched_valid without a matching item at issue");
            fail_cnt++;
        end
    a_quiet_reset: assert property (p_quiet_reset)
        else begin
            $error("valid output during reset");
            fail_cnt++;
        end

endmodule

bind decode_stage decode_asserts decode_asserts0 (
    .clk         (clk),
    .rst_n       (rst_n),
    .fetch_valid (fetch_valid),
    .fetch_ready (fetch_ready),
    .issue_valid (issue_valid),
    .issue_ready (issue_ready),
    .issue_data  (issue_data),
    .sched_valid (sched_valid),
    .sched_data  (sched_data)
);

// ==== tb_decode_stage.sv ====
`timescale 1ns/10ps
////////////////////////////////////////
// Decode stage testbench
// Replays golden fetches under random
// issue back-pressure and checks results
////////////////////////////////////////
`include "decode_config.svh"

module tb_decode_stage;

    localparam int WAIT_LIMIT = 200; // Cycles per wait

    logic                        clk = 1'b0;
    logic                        rst_n;
    logic                        fetch_valid;
    logic                        fetch_ready;
    gpu_decode_pkg::fetch_t      fetch_data;
    logic                        issue_valid;
    logic                        issue_ready = 1'b0;
    gpu_decode_pkg::decoded_t    issue_data;
    logic                        sched_valid;
    gpu_decode_pkg::sched_note_t sched_data;

    gpu_decode_pkg::fetch_t      fetch_q[$];
    gpu_decode_pkg::decoded_t    result_q[$];
    gpu_decode_pkg::sched_note_t note_q[$];

    integer seed = 69584;
    int     n_items;
    int     n_results;
    int     n_notes;
    int     value_errs;
    int     proto_errs;
    bit     timed_out;
    bit     buf_full; // Expected buffer occupancy

    decode_stage dut0 (
        .clk         (clk),
        .rst_n       (rst_n),
        .fetch_valid (fetch_valid),
        .fetch_ready (fetch_ready),
        .fetch_data  (fetch_data),
        .issue_valid (issue_valid),
        .issue_ready (issue_ready),
        .issue_data  (issue_data),
        .sched_valid (sched_valid),
        .sched_data  (sched_data)
    );

    always #20 clk = ~clk;

    // Roughly one stall cycle in four
    always @(negedge clk) begin
        issue_ready = ($random(seed) & 3) != 0;
    end

    task automatic report_mismatch(input string name, input logic [31:0] expv,
                                   input logic [31:0] gotv);
        $display("ERR %0t ns %s expected %h actual %h", $time, name, expv, gotv);
        value_errs++;
    endtask

    task automatic check_decoded(input gpu_decode_pkg::decoded_t expv,
                                 input gpu_decode_pkg::decoded_t gotv);
        if (gotv.uuid !== expv.uuid)
            report_mismatch("issue_data.uuid", expv.uuid, gotv.uuid);
        if (gotv.wid !== expv.wid)
            report_mismatch("issue_data.wid", expv.wid, gotv.wid);
        if (gotv.tmask !== expv.tmask)
            report_mismatch("issue_data.tmask", expv.tmask, gotv.tmask);
        if (gotv.pc !== expv.pc)
            report_mismatch("issue_data.pc", expv.pc, gotv.pc);
        if (gotv.ex_type !== expv.ex_type)
            report_mismatch("issue_data.ex_type", expv.ex_type, gotv.ex_type);
        if (gotv.op_type !== expv.op_type)
            report_mismatch("issue_data.op_type", expv.op_type, gotv.op_type);
        if (gotv.op_args !== expv.op_args)
            report_mismatch("issue_data.op_args", expv.op_args, gotv.op_args);
        if (gotv.wb !== expv.wb)
            report_mismatch("issue_data.wb", expv.wb, gotv.wb);
        if (gotv.used_rs !== expv.used_rs)
            report_mismatch("issue_data.used_rs", expv.used_rs, gotv.used_rs);
        if (gotv.rd !== expv.rd)
            report_mismatch("issue_data.rd", expv.rd, gotv.rd);
        if (gotv.rs1 !== expv.rs1)
            report_mismatch("issue_data.rs1", expv.rs1, gotv.rs1);
        if (gotv.rs2 !== expv.rs2)
            report_mismatch("issue_data.rs2", expv.rs2, gotv.rs2);
    endtask

    task automatic check_sched(input gpu_decode_pkg::sched_note_t expv,
                               input gpu_decode_pkg::sched_note_t gotv);
        if (gotv.wid !== expv.wid)
            report_mismatch("sched_data.wid", expv.wid, gotv.wid);
        if (gotv.unlock !== expv.unlock)
            report_mismatch("sched_data.unlock", expv.unlock, gotv.unlock);
    endtask

    task automatic load_golden();
        int                               fd;
        int                               cnt;
        string                            line;
        logic [31:0]                      instr;
        logic [gpu_decode_pkg::WID_W-1:0] wid;
        logic [31:0]                      pc;
        logic [1:0]                       ex;
        logic [3:0]                       op;
        logic                             wb;
        logic [2:0]                       used;
        gpu_decode_pkg::reg_id_t          rd;
        gpu_decode_pkg::reg_id_t          rs1;
        gpu_decode_pkg::reg_id_t          rs2;
        logic [23:0]                      args;
        logic                             unlock;
        gpu_decode_pkg::fetch_t           fe;
        gpu_decode_pkg::decoded_t         de;
        gpu_decode_pkg::sched_note_t      sn;
        fd = $fopen("decode_golden.txt", "r");
        if (fd == 0) begin
            $display("Could not open decode_golden.txt");
            proto_errs++;
            return;
        end
        while ($fgets(line, fd) != 0) begin
            if (line.len() < 2 || line.getc(0) == "#")
                continue;
            cnt = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h",
                          instr, wid, pc, ex, op, wb, used, rd, rs1, rs2, args, unlock);
            if (cnt != 12) begin
                $display("Golden entry %0d is malformed", n_items + 1);
                proto_errs++;
                continue;
            end
            fe.uuid  = n_items[`DEC_UUID_W-1:0];
            fe.wid   = wid;
            fe.tmask = `DEC_NUM_THREADS'(n_items + 1);
            fe.pc    = pc;
            fe.instr = instr;
            de.uuid    = fe.uuid; // Fetch side passes through
            de.wid     = wid;
            de.tmask   = fe.tmask;
            de.pc      = pc;
            de.ex_type = gpu_decode_pkg::ex_type_e'(ex);
            de.op_type = op;
            de.op_args = gpu_decode_pkg::op_args_t'(args);
            de.wb      = wb;
            de.used_rs = used;
            de.rd      = rd;
            de.rs1     = rs1;
            de.rs2     = rs2;
            sn.wid    = wid;
            sn.unlock = unlock;
            fetch_q.push_back(fe);
            result_q.push_back(de);
            note_q.push_back(sn);
            n_items++;
        end
        $fclose(fd);
    endtask

    task automatic wait_fetch_accept();
        int   cycles;
        logic taken;
        cycles = 0;
        taken  = 1'b0;
        while (!taken && cycles < WAIT_LIMIT) begin
            @(posedge clk);
            taken = fetch_ready;
            cycles++;
        end
        if (!taken) begin
            $display("Timeout: fetch %h was never accepted", fetch_data.instr);
            timed_out = 1'b1;
        end
    endtask

    // Outputs sampled at the rising edge, before the DUT updates
    always @(posedge clk) begin
        if (rst_n && issue_valid && issue_ready) begin
            if (result_q.size() == 0) begin
                $display("Unexpected result at %0t ns with nothing pending", $time);
                proto_errs++;
            end else begin
                check_decoded(result_q.pop_front(), issue_data);
            end
            n_results++;
        end
        if (rst_n && sched_valid) begin
            if (note_q.size() == 0) begin
                $display("Unexpected scheduler notice at %0t ns", $time);
                proto_errs++;
            end else begin
                check_sched(note_q.pop_front(), sched_data);
            end
            n_notes++;
        end
    end

    // One-entry buffer, item visible one cycle after acceptance
    always @(posedge clk) begin
        if (!rst_n) begin
            buf_full = 1'b0;
        end else begin
            if (issue_valid !== buf_full)
                report_mismatch("issue_valid", buf_full, issue_valid);
            if (fetch_ready !== (!buf_full || issue_ready))
                report_mismatch("fetch_ready", !buf_full || issue_ready, fetch_ready);
            if (fetch_valid && (!buf_full || issue_ready))
                buf_full = 1'b1;
            else if (issue_ready)
                buf_full = 1'b0;
        end
    end

    initial begin
        int cycles;
        rst_n       = 1'b1;
        fetch_valid = 1'b0;
        fetch_data  = '0;
        load_golden();
        if (n_items == 0) begin
            $display("No instructions were loaded from the golden file");
            proto_errs++;
        end
        #1 rst_n = 1'b0; // Clean falling edge on reset
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        while (fetch_q.size() > 0 && !timed_out) begin
            @(negedge clk);
            fetch_valid = 1'b1;
            fetch_data  = fetch_q.pop_front();
            wait_fetch_accept();
        end
        @(negedge clk);
        fetch_valid = 1'b0;

        cycles = 0;
        while (!timed_out && n_results < n_items) begin
            @(posedge clk);
            cycles++;
            if (cycles > WAIT_LIMIT) begin
                $display("Timeout: %0d of %0d results reached issue", n_results, n_items);
                timed_out = 1'b1;
            end
        end
        if (n_notes != n_items) begin
            $display("Scheduler saw %0d notices for %0d fetches", n_notes, n_items);
            proto_errs++;
        end

        $display("Errors: %0d value, %0d protocol, %0d assertion, timeout %0d",
                 value_errs, proto_errs, dut0.decode_asserts0.fail_cnt, timed_out);
        if (value_errs == 0 && proto_errs == 0 && !timed_out &&
            dut0.decode_asserts0.fail_cnt == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// ==== decode_golden.txt ====
# instr wid pc | expected ex_type op_type wb used_rs rd rs1 rs2 op_args unlock
# all hex, ex_type 0 ALU 1 LSU 2 SFU
fff30293 0 00001000 0 0 1 1 05 06 00 1fffff 1
40345393 1 00001004 0 7 1 1 07 08 00 100003 1
403100b3 2 00001008 0 1 1 3 01 02 03 000000 1
0262b233 3 0000100c 0 3 1 3 04 05 06 800000 1
12345537 0 00001010 0 a 1 0 0a 00 00 112345 1
80000597 1 00001014 0 b 1 0 0b 00 00 380000 1
008000ef 2 00001018 0 b 1 0 01 00 00 700004 0
00008067 3 0000101c 0 c 0 1 00 01 00 500000 0
fe629ee3 0 00001020 0 1 0 3 00 05 06 7ffffe 0
00000073 1 00001024 0 6 0 0 00 00 00 700004 0
30200073 2 00001028 0 a 0 0 00 00 00 700004 0
00c42383 3 0000102c 1 2 1 1 07 08 00 00000c 1
fe952c23 0 00001030 1 a 0 3 00 0a 09 001ff8 1
0ff0000f 1 00001034 1 f 0 0 00 00 00 000000 1
300021f3 2 00001038 2 9 1 1 03 00 00 000300 1
3412d073 3 0000103c 2 8 0 0 00 00 00 0a5341 1
34223173 0 00001040 2 a 1 1 02 04 00 084342 1
0002800b 1 00001044 2 0 0 1 00 05 00 000000 0
0013a30b 2 00001048 2 2 1 1 06 07 00 040000 0
0094508b 3 0000104c 2 5 0 3 00 08 09 040000 0
00d6600b 0 00001050 2 6 0 3 00 0c 0d 000000 0

// ==== sim.f ====
+incdir+.
rv_isa_pkg.sv
gpu_decode_pkg.sv
op_select.sv
unit_decode.sv
decode_buf.sv
decode_stage.sv
decode_asserts.sv
tb_decode_stage.sv

// ==== Makefile ====
VERILATOR := verilator
VFLAGS    := --timing --assert
TOP       := tb_decode_stage
FILELIST  := sim.f
LOG       := sim.log
FAIL_MSG  := TESTBENCH FAILED
PASS_MSG  := TESTBENCH PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -o $(TOP)
	-./obj_dir/$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Simulation did not complete"; exit 1; fi

clean:
	rm -rf obj_dir $(LOG)
